/* flist.f */
+incdir+source
source/hpdc_mem_pkg.sv
source/l15_pkg.sv
source/thread_ctx_if.sv
source/l15_req_encoder.sv
source/l15_issue_fsm.sv
source/thread_id_free_list.sv
source/thread_ctx_table.sv
source/l15_resp_decoder.sv
source/hpdc_l15_adapter.sv
sim/tb_hpdc_l15_adapter.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the adapter testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing -f flist.f --top-module tb_hpdc_l15_adapter -o sim_tb \
    > build.log 2>&1 \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    && ! grep -q "ERRORS FOUND" sim.log \
    && grep -q "NO ERRORS" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see build.log and sim.log"; exit 1; }

/* sim/adapter_stimulus.txt */
# name pid id cmd cach addr size wdata be hdr ack flush | exp: rqtype nc size addr data be
# | return: data type | exp: resp_data error
ifill_c 0 1 0 1 0000001040 3 0000000000000000 00 0 0 0 10 0 6 0000001040 0000000000000000 00 00112233445566778899aabbccddeeff 1 7766554433221100ffeeddccbbaa9988 0
ifill_nc 0 2 0 0 0000002000 3 0000000000000000 00 1 1 0 10 1 3 0000002000 0000000000000000 00 0123456789abcdeffedcba9876543210 1 efcdab89674523011032547698badcfe 0
ld_dc 1 3 0 1 0000003008 3 0000000000000000 00 0 2 0 00 0 4 0000003008 0000000000000000 00 00112233445566778899aabbccddeeff 0 7766554433221100ffeeddccbbaa9988 0
ld_unc 3 4 0 0 0000004004 2 0000000000000000 00 2 2 0 00 1 3 0000004004 0000000000000000 00 0123456789abcdeffedcba9876543210 0 efcdab89674523011032547698badcfe 0
st_wb_b1 2 5 1 1 0000005000 3 1122334455667788 20 0 0 1 01 0 1 0000005005 8877665544332211 04 00112233445566778899aabbccddeeff 4 7766554433221100ffeeddccbbaa9988 0
st_wb_b2 2 6 1 1 0000006000 3 1122334455667788 0c 1 2 0 01 0 2 0000006002 8877665544332211 30 0123456789abcdeffedcba9876543210 4 efcdab89674523011032547698badcfe 0
st_wb_b4 2 7 1 1 0000007000 3 1122334455667788 f0 0 0 0 01 0 3 0000007004 8877665544332211 0f 00112233445566778899aabbccddeeff 4 7766554433221100ffeeddccbbaa9988 0
st_wb_b8 2 8 1 1 0000008000 3 1122334455667788 ff 0 1 1 01 0 4 0000008000 8877665544332211 ff 0123456789abcdeffedcba9876543210 4 efcdab89674523011032547698badcfe 0
st_unc_b1 4 9 1 0 0000009003 0 1122334455667788 08 0 0 0 01 1 1 0000009003 5555555555555555 10 00112233445566778899aabbccddeeff 4 7766554433221100ffeeddccbbaa9988 0
st_unc_b2 4 a 1 0 0000009004 1 1122334455667788 30 2 3 0 01 1 2 0000009004 4433443344334433 0c 0123456789abcdeffedcba9876543210 4 efcdab89674523011032547698badcfe 0
st_unc_b4 4 b 1 0 000000a000 2 1122334455667788 0f 0 0 1 01 1 3 000000a000 8877665588776655 f0 00112233445566778899aabbccddeeff c 7766554433221100ffeeddccbbaa9988 1
st_unc_b8 4 c 1 0 000000a008 3 1122334455667788 ff 1 3 0 01 1 4 000000a008 8877665544332211 ff 0123456789abcdeffedcba9876543210 4 efcdab89674523011032547698badcfe 0
ld_err 1 f 0 1 000000b010 3 0000000000000000 00 0 1 1 00 0 4 000000b010 0000000000000000 00 00112233445566778899aabbccddeeff c 7766554433221100ffeeddccbbaa9988 1

/* sim/tb_hpdc_l15_adapter.sv */
`timescale 1ns/100ps
`default_nettype none

`include "l15_adapter_cfg.svh"

module tb_hpdc_l15_adapter import hpdc_mem_pkg::*, l15_pkg::*;;

    localparam int max_lines = 32;

    logic clk_i = 1'b0;
    logic rst_ni;
    logic req_valid_i, req_ready_o, req_cacheable_i, resp_ready_i, resp_valid_o, resp_error_o;
    mem_pid_t req_pid_i, resp_pid_o;
    mem_id_t req_id_i, resp_id_o;
    mem_cmd_e req_cmd_i;
    mem_addr_t req_addr_i, l15_address_o;
    mem_size_t req_size_i;
    mem_word_t req_wdata_i, l15_data_o;
    mem_be_t req_be_i, l15_be_o;
    l15_rtrn_data_t resp_data_o, l15_rtrn_data_i;
    logic l15_val_o, l15_nc_o, l15_req_ack_o, l15_header_ack_i, l15_ack_i, l15_rtrn_val_i;
    l15_rqtype_e l15_rqtype_o;
    l15_size_t l15_size_o;
    l15_tid_t l15_threadid_o, l15_rtrn_threadid_i;
    l15_rtrn_e l15_rtrn_type_i;

    // One entry per stimulus line
    string names [max_lines];
    logic [2:0] pid [max_lines];
    logic [3:0] id [max_lines];
    logic cmd [max_lines], cach [max_lines], flush [max_lines];
    logic [39:0] addr [max_lines], exp_addr [max_lines];
    logic [2:0] size [max_lines], exp_size [max_lines];
    logic [63:0] wdata [max_lines], exp_data [max_lines];
    logic [7:0] be [max_lines], exp_be [max_lines];
    int hdr_dly [max_lines], ack_dly [max_lines];
    logic [4:0] exp_rq [max_lines];
    logic exp_nc [max_lines], exp_err [max_lines];
    logic [127:0] rdata [max_lines], exp_rdata [max_lines];
    logic [3:0] rtype [max_lines];

    int n_lines = 0;
    int error_count = 0;
    int unsigned cycle_cnt = 0;
    int unsigned cycle_limit = 0;
    integer seed = 32'h300a;
    l15_tid_t free_q [$];  // Model of the free thread ids
    int pend_idx [$];      // Outstanding requests, oldest first
    l15_tid_t pend_tid [$];

    hpdc_l15_adapter UUT (.*);

    always #5 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit != 0 && cycle_cnt > cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("ERRORS FOUND");
            $fatal(1, "Run stopped after timeout");
        end
    end

    task automatic check_value(input string test, input string field,
                               input logic [127:0] exp, input logic [127:0] act);
        if (exp !== act) begin
            error_count++;
            $display("Mismatch %s %s expected %h actual %h", test, field, exp, act);
            $display("ERRORS FOUND");
            $fatal(1, "First mismatch");
        end
    endtask

    // L1.5 sends the return of an outstanding request, held until accepted
    task automatic return_entry(input int pos);
        int idx;
        l15_tid_t tid;
        logic [31:0] rnd;
        logic accepted;
        idx = pend_idx[pos];
        tid = pend_tid[pos];
        pend_idx.delete(pos);
        pend_tid.delete(pos);
        accepted = 1'b0;
        while (!accepted) begin
            @(posedge clk_i);
            rnd = $random(seed);
            l15_rtrn_val_i      <= 1'b1;
            l15_rtrn_type_i     <= l15_rtrn_e'(rtype[idx]);
            l15_rtrn_threadid_i <= tid;
            l15_rtrn_data_i     <= rdata[idx];
            resp_ready_i        <= rnd[0];
            @(negedge clk_i);
            check_value(names[idx], "resp_valid", 1, resp_valid_o);
            check_value(names[idx], "resp_id", id[idx], resp_id_o);
            check_value(names[idx], "resp_pid", pid[idx], resp_pid_o);
            check_value(names[idx], "resp_data", exp_rdata[idx], resp_data_o);
            check_value(names[idx], "resp_error", exp_err[idx], resp_error_o);
            check_value(names[idx], "req_ack", resp_ready_i, l15_req_ack_o);
            accepted = resp_ready_i;
        end
        @(posedge clk_i);
        l15_rtrn_val_i <= 1'b0;
        resp_ready_i   <= 1'b0;
        free_q.push_back(tid);
    endtask

    task automatic issue_request(input int idx);
        int k;
        logic done;
        @(posedge clk_i);
        req_valid_i <= 1'b1;
        req_pid_i <= pid[idx];
        req_id_i <= id[idx];
        req_cmd_i <= mem_cmd_e'(cmd[idx]);
        req_cacheable_i <= cach[idx];
        req_addr_i <= addr[idx];
        req_size_i <= size[idx];
        req_wdata_i <= wdata[idx];
        req_be_i <= be[idx];
        if (free_q.size() == 0) begin
            repeat (3) begin
                @(negedge clk_i);
                check_value(names[idx], "val_stall", 0, l15_val_o);
            end
            return_entry(0);
        end
        @(negedge clk_i);
        check_value(names[idx], "val_first", 1, l15_val_o);
        check_value(names[idx], "ready_first", 0, req_ready_o);
        k = 0;
        done = 1'b0;
        while (!done) begin
            @(posedge clk_i);
            l15_header_ack_i <= (k == hdr_dly[idx]);
            l15_ack_i        <= (k == ack_dly[idx]);
            @(negedge clk_i);
            check_value(names[idx], "val", k <= hdr_dly[idx], l15_val_o);
            check_value(names[idx], "req_ready", k == ack_dly[idx], req_ready_o);
            if (k <= hdr_dly[idx]) begin
                check_value(names[idx], "rqtype", exp_rq[idx], l15_rqtype_o);
                check_value(names[idx], "nc", exp_nc[idx], l15_nc_o);
                check_value(names[idx], "size", exp_size[idx], l15_size_o);
                check_value(names[idx], "address", exp_addr[idx], l15_address_o);
                check_value(names[idx], "data", exp_data[idx], l15_data_o);
                check_value(names[idx], "be", exp_be[idx], l15_be_o);
            end
            if (k == ack_dly[idx]) begin
                check_value(names[idx], "threadid", free_q[0], l15_threadid_o);
                pend_idx.push_back(idx);
                pend_tid.push_back(free_q.pop_front());
                done = 1'b1;
            end
            k++;
        end
        @(posedge clk_i);
        req_valid_i      <= 1'b0;
        l15_header_ack_i <= 1'b0;
        l15_ack_i        <= 1'b0;
    endtask

    initial begin
        int fd;
        int cnt;
        string line;
        rst_ni = 1'b0;
        req_valid_i = 1'b0;
        req_pid_i = '0;
        req_id_i = '0;
        req_cmd_i = MEM_READ;
        req_cacheable_i = 1'b0;
        req_addr_i = '0;
        req_size_i = '0;
        req_wdata_i = '0;
        req_be_i = '0;
        resp_ready_i = 1'b0;
        l15_header_ack_i = 1'b0;
        l15_ack_i = 1'b0;
        l15_rtrn_val_i = 1'b0;
        l15_rtrn_type_i = L15_LOAD_RET;
        l15_rtrn_threadid_i = '0;
        l15_rtrn_data_i = '0;
        for (int i = 0; i < `NUM_TIDS; i++) free_q.push_back(l15_tid_t'(i));

        fd = $fopen("sim/adapter_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file sim/adapter_stimulus.txt");
            $display("ERRORS FOUND");
            $fatal(1, "No stimulus");
        end
        while (!$feof(fd) && n_lines < max_lines) begin
            line = "";
            cnt = $fgets(line, fd);
            if (line.len() > 1 && line.getc(0) != 8'h23) begin  // Skip comment lines
                cnt = $sscanf(line, "%s %h %h %h %h %h %h %h %h %d %d %h %h %h %h %h %h %h %h %h %h %h",
                    names[n_lines], pid[n_lines], id[n_lines], cmd[n_lines], cach[n_lines],
                    addr[n_lines], size[n_lines], wdata[n_lines], be[n_lines],
                    hdr_dly[n_lines], ack_dly[n_lines], flush[n_lines], exp_rq[n_lines],
                    exp_nc[n_lines], exp_size[n_lines], exp_addr[n_lines], exp_data[n_lines],
                    exp_be[n_lines], rdata[n_lines], rtype[n_lines], exp_rdata[n_lines],
                    exp_err[n_lines]);
                if (cnt == 22) n_lines++;
            end
        end
        $fclose(fd);
        cycle_limit = 64 * n_lines + 100;

        repeat (2) @(posedge clk_i);
        rst_ni <= 1'b1;
        @(negedge clk_i);
        check_value("reset", "val", 0, l15_val_o);
        check_value("reset", "req_ready", 0, req_ready_o);
        check_value("reset", "resp_valid", 0, resp_valid_o);
        check_value("reset", "req_ack", 0, l15_req_ack_o);

        for (int i = 0; i < n_lines; i++) begin
            issue_request(i);
            if (flush[i]) begin
                while (pend_idx.size() > 0) return_entry(pend_idx.size() - 1);  // Newest first
            end
        end
        while (pend_idx.size() > 0) return_entry(0);

        if (error_count == 0 && n_lines > 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* source/hpdc_l15_adapter.sv */
`timescale 1ns/100ps
`default_nettype none

module hpdc_l15_adapter import hpdc_mem_pkg::*, l15_pkg::*; (
    input  logic           clk_i,
    input  logic           rst_ni,

    // Cache request side
    input  logic           req_valid_i,
    output logic           req_ready_o,
    input  mem_pid_t       req_pid_i,
    input  mem_id_t        req_id_i,
    input  mem_cmd_e       req_cmd_i,
    input  logic           req_cacheable_i,
    input  mem_addr_t      req_addr_i,
    input  mem_size_t      req_size_i,
    input  mem_word_t      req_wdata_i,
    input  mem_be_t        req_be_i,

    // Cache response side
    input  logic           resp_ready_i,
    output logic           resp_valid_o,
    output mem_pid_t       resp_pid_o,
    output mem_id_t        resp_id_o,
    output l15_rtrn_data_t resp_data_o,
    output logic           resp_error_o,

    // L1.5 request
    output logic           l15_val_o,
    output l15_rqtype_e    l15_rqtype_o,
    output logic           l15_nc_o,
    output l15_size_t      l15_size_o,
    output l15_tid_t       l15_threadid_o,
    output mem_addr_t      l15_address_o,
    output mem_word_t      l15_data_o,
    output mem_be_t        l15_be_o,
    output logic           l15_req_ack_o,

    // L1.5 acks and return
    input  logic           l15_header_ack_i,
    input  logic           l15_ack_i,
    input  logic           l15_rtrn_val_i,
    input  l15_rtrn_e      l15_rtrn_type_i,
    input  l15_tid_t       l15_rtrn_threadid_i,
    input  l15_rtrn_data_t l15_rtrn_data_i
);

    logic     tid_avail;
    logic     tid_pop;
    logic     tid_push;
    l15_tid_t head_tid;  // Next free id, used by the pending request
    l15_tid_t push_tid;

    thread_ctx_if ctx_bus ();

    assign l15_threadid_o = head_tid;

    l15_req_encoder u_encoder (
        .req_pid_i, .req_cmd_i, .req_cacheable_i, .req_addr_i, .req_size_i,
        .req_wdata_i, .req_be_i,
        .l15_rqtype_o, .l15_nc_o, .l15_size_o, .l15_address_o, .l15_data_o, .l15_be_o
    );

    l15_issue_fsm u_issue (
        .clk_i, .rst_ni, .req_valid_i, .req_id_i, .req_pid_i,
        .tid_avail_i (tid_avail),
        .tid_i       (head_tid),
        .l15_header_ack_i, .l15_ack_i, .req_ready_o, .l15_val_o,
        .tid_pop_o   (tid_pop),
        .ctx         (ctx_bus.writer)
    );

    thread_id_free_list u_free_list (
        .clk_i, .rst_ni,
        .pop_i      (tid_pop),
        .push_i     (tid_push),
        .push_tid_i (push_tid),
        .avail_o    (tid_avail),
        .head_tid_o (head_tid)
    );

    thread_ctx_table u_ctx_table (.clk_i, .rst_ni, .ctx (ctx_bus.ctx_table));

    l15_resp_decoder u_decoder (
        .l15_rtrn_val_i, .l15_rtrn_type_i, .l15_rtrn_threadid_i, .l15_rtrn_data_i,
        .resp_ready_i, .resp_valid_o, .resp_pid_o, .resp_id_o, .resp_data_o,
        .resp_error_o, .l15_req_ack_o,
        .tid_push_o (tid_push),
        .tid_o      (push_tid),
        .ctx        (ctx_bus.reader)
    );

endmodule

`default_nettype wire

/* source/hpdc_mem_pkg.sv */
`default_nettype none

`include "l15_adapter_cfg.svh"

package hpdc_mem_pkg;

    // Command of a cache memory request
    typedef enum logic {
        MEM_READ  = 1'b0,
        MEM_WRITE = 1'b1
    } mem_cmd_e;

    // Request id, echoed back with the response
    typedef logic [`MEM_ID_W-1:0] mem_id_t;

    // Source port in the request mux
    typedef logic [`PID_W-1:0] mem_pid_t;

    typedef logic [`PA_W-1:0] mem_addr_t;

    // Log2 of the byte count
    typedef logic [2:0] mem_size_t;

    // One data word and its byte mask
    typedef logic [`WORD_W-1:0] mem_word_t;
    typedef logic [`WORD_W/8-1:0] mem_be_t;

endpackage

`default_nettype wire

/* source/l15_adapter_cfg.svh */
`ifndef L15_ADAPTER_CFG_SVH
`define L15_ADAPTER_CFG_SVH

// Thread ids towards the L1.5
`define L15_TID_W 2
`define NUM_TIDS 4

// Widths on the cache side
`define PA_W 40
`define MEM_ID_W 4
`define PID_W 3
`define WORD_W 64
`define RTRN_W 128 // Two 64-bit return packets

// Source ports of the cache request mux
`define PORT_ICACHE 0
`define PORT_DCACHE 1
`define PORT_WBUF 2
`define PORT_UNC_RD 3
`define PORT_UNC_WR 4

`define ICACHE_UNC_SIZE 3 // 4B uncached fill
`define SWAP_ENDIAN 1 // L1.5 is big-endian

`endif

/* source/l15_issue_fsm.sv */
`timescale 1ns/100ps
`default_nettype none

module l15_issue_fsm import hpdc_mem_pkg::*, l15_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_ni,
    input  logic     req_valid_i,
    input  mem_id_t  req_id_i,
    input  mem_pid_t req_pid_i,
    input  logic     tid_avail_i,
    input  l15_tid_t tid_i,
    input  logic     l15_header_ack_i,
    input  logic     l15_ack_i,
    output logic     req_ready_o,
    output logic     l15_val_o,
    output logic     tid_pop_o,
    thread_ctx_if.writer ctx
);

    typedef enum logic [1:0] {
        IDLE,
        WAIT_HDR,  // Val held high until header_ack
        WAIT_ACK   // Val low, fields held until ack
    } state_e;

    state_e state_q, state_d;
    logic   ack_done;

    always_comb begin
        state_d   = state_q;
        l15_val_o = 1'b0;
        ack_done  = 1'b0;
        case (state_q)
            IDLE: begin
                if (req_valid_i && tid_avail_i) begin
                    l15_val_o = 1'b1;
                    if (!l15_header_ack_i)  state_d = WAIT_HDR;
                    else if (l15_ack_i)     ack_done = 1'b1;
                    else                    state_d = WAIT_ACK;
                end
            end
            WAIT_HDR: begin
                l15_val_o = 1'b1;
                if (l15_header_ack_i) begin
                    if (l15_ack_i) ack_done = 1'b1;
                    else           state_d = WAIT_ACK;
                end
            end
            default: ack_done = l15_ack_i;  // WAIT_ACK
        endcase
        if (ack_done) state_d = IDLE;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) state_q <= IDLE;
        else         state_q <= state_d;
    end

    // Completion in the ack cycle
    assign req_ready_o = ack_done;
    assign tid_pop_o   = ack_done;
    assign ctx.wr_en   = ack_done;
    assign ctx.wr_tid  = tid_i;
    assign ctx.wr_id   = req_id_i;
    assign ctx.wr_pid  = req_pid_i;

endmodule

`default_nettype wire

/* source/l15_pkg.sv */
`default_nettype none

`include "l15_adapter_cfg.svh"

package l15_pkg;

    // Request types as seen by the L1.5
    typedef enum logic [4:0] {
        L15_LOAD_RQ  = 5'b00000,
        L15_STORE_RQ = 5'b00001,
        L15_IMISS_RQ = 5'b10000
    } l15_rqtype_e;

    // Return types, error return included
    typedef enum logic [3:0] {
        L15_LOAD_RET  = 4'b0000,
        L15_IFILL_RET = 4'b0001,
        L15_ST_ACK    = 4'b0100,
        L15_ERR_RET   = 4'b1100
    } l15_rtrn_e;

    typedef logic [2:0] l15_size_t;
    typedef logic [`L15_TID_W-1:0] l15_tid_t;
    typedef logic [`RTRN_W-1:0] l15_rtrn_data_t;

    // Byte reversal of a 64-bit word for the big-endian L1.5
    function automatic logic [`WORD_W-1:0] swap_bytes64(input logic [`WORD_W-1:0] din);
        logic [`WORD_W-1:0] dout;
        for (int i = 0; i < `WORD_W/8; i++) begin
            dout[i*8 +: 8] = din[(`WORD_W/8-1-i)*8 +: 8];
        end
        return dout;
    endfunction

endpackage

`default_nettype wire

/* source/l15_req_encoder.sv */
`timescale 1ns/100ps
`default_nettype none

`include "l15_adapter_cfg.svh"

module l15_req_encoder import hpdc_mem_pkg::*, l15_pkg::*; (
    input  mem_pid_t    req_pid_i,
    input  mem_cmd_e    req_cmd_i,
    input  logic        req_cacheable_i,
    input  mem_addr_t   req_addr_i,
    input  mem_size_t   req_size_i,
    input  mem_word_t   req_wdata_i,
    input  mem_be_t     req_be_i,
    output l15_rqtype_e l15_rqtype_o,
    output logic        l15_nc_o,
    output l15_size_t   l15_size_o,
    output mem_addr_t   l15_address_o,
    output mem_word_t   l15_data_o,
    output mem_be_t     l15_be_o
);

    localparam mem_pid_t port_icache = mem_pid_t'(`PORT_ICACHE);
    localparam mem_pid_t port_wbuf   = mem_pid_t'(`PORT_WBUF);
    localparam mem_pid_t port_unc_wr = mem_pid_t'(`PORT_UNC_WR);

    logic      is_ifill;
    logic      is_wbuf_st;
    logic      is_unc_st;
    logic [3:0] num_ones;
    logic [2:0] low_pos;   // Lowest set bit of the mask
    mem_size_t  st_size;
    logic [2:0] st_offset;
    mem_word_t  shifted;
    mem_word_t  rep_data;

    assign is_ifill   = (req_pid_i == port_icache);
    assign is_wbuf_st = (req_pid_i == port_wbuf) && (req_cmd_i == MEM_WRITE);
    assign is_unc_st  = (req_pid_i == port_unc_wr) && (req_cmd_i == MEM_WRITE);

    assign l15_rqtype_o = is_ifill ? L15_IMISS_RQ :
                          (is_wbuf_st || is_unc_st) ? L15_STORE_RQ :
                          L15_LOAD_RQ;  // Dcache and uncached reads
    assign l15_nc_o     = ~req_cacheable_i;

    assign num_ones = 4'($countones(req_be_i));

    always_comb begin
        low_pos = '0;
        for (int i = `WORD_W/8 - 1; i >= 0; i--) begin
            if (req_be_i[i]) low_pos = 3'(i);
        end
    end

    // Store size and aligned offset from the byte mask
    always_comb begin
        st_offset = low_pos;
        case (num_ones)
            4'd1:    st_size = 3'd0;
            4'd2:    st_size = 3'd1;
            4'd4:    st_size = 3'd2;
            default: begin
                st_size   = 3'd3;  // Full dword
                st_offset = '0;
            end
        endcase
    end

    assign l15_size_o = is_ifill ? (req_cacheable_i ? 3'd6 : 3'(`ICACHE_UNC_SIZE)) :
                        is_wbuf_st ? st_size + 3'd1 :
                        req_size_i + 3'd1;

    assign l15_address_o = is_wbuf_st ? {req_addr_i[`PA_W-1:3], st_offset} : req_addr_i;

    // Replicate the written bytes over the dword for uncached stores
    assign shifted = req_wdata_i >> {st_offset, 3'b000};

    always_comb begin
        case (st_size)
            3'd0:    rep_data = {8{shifted[7:0]}};
            3'd1:    rep_data = {4{shifted[15:0]}};
            3'd2:    rep_data = {2{shifted[31:0]}};
            default: rep_data = req_wdata_i;
        endcase
        if (!is_unc_st) rep_data = req_wdata_i;
    end

    assign l15_data_o = (`SWAP_ENDIAN != 0) ? swap_bytes64(rep_data) : rep_data;

    always_comb begin
        for (int i = 0; i < `WORD_W/8; i++) begin
            l15_be_o[i] = req_be_i[`WORD_W/8-1-i];  // Byte 0 is the MSB lane
        end
    end

endmodule

`default_nettype wire

/* source/l15_resp_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

`include "l15_adapter_cfg.svh"

module l15_resp_decoder import hpdc_mem_pkg::*, l15_pkg::*; (
    input  logic           l15_rtrn_val_i,
    input  l15_rtrn_e      l15_rtrn_type_i,
    input  l15_tid_t       l15_rtrn_threadid_i,
    input  l15_rtrn_data_t l15_rtrn_data_i,
    input  logic           resp_ready_i,
    output logic           resp_valid_o,
    output mem_pid_t       resp_pid_o,
    output mem_id_t        resp_id_o,
    output l15_rtrn_data_t resp_data_o,
    output logic           resp_error_o,
    output logic           l15_req_ack_o,
    output logic           tid_push_o,
    output l15_tid_t       tid_o,
    thread_ctx_if.reader   ctx
);

    assign ctx.rd_tid   = l15_rtrn_threadid_i;
    assign resp_valid_o = l15_rtrn_val_i;
    assign resp_pid_o   = ctx.rd_pid;  // Back to the issuing port
    assign resp_id_o    = ctx.rd_id;
    assign resp_error_o = (l15_rtrn_type_i == L15_ERR_RET);

    always_comb begin
        for (int i = 0; i < `RTRN_W/`WORD_W; i++) begin
            resp_data_o[i*`WORD_W +: `WORD_W] = (`SWAP_ENDIAN != 0) ?
                swap_bytes64(l15_rtrn_data_i[i*`WORD_W +: `WORD_W]) :
                l15_rtrn_data_i[i*`WORD_W +: `WORD_W];
        end
    end

    // Accepted return frees its thread id
    assign l15_req_ack_o = l15_rtrn_val_i & resp_ready_i;
    assign tid_push_o    = l15_req_ack_o;
    assign tid_o         = l15_rtrn_threadid_i;

endmodule

`default_nettype wire

/* source/thread_ctx_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface thread_ctx_if import hpdc_mem_pkg::*, l15_pkg::*;;

    // Context write on the issue side
    logic     wr_en;
    l15_tid_t wr_tid;
    mem_id_t  wr_id;
    mem_pid_t wr_pid;

    // Lookup on the return side
    l15_tid_t rd_tid;
    mem_id_t  rd_id;
    mem_pid_t rd_pid;

    modport writer (output wr_en, output wr_tid, output wr_id, output wr_pid);

    modport reader (output rd_tid, input rd_id, input rd_pid);

    modport ctx_table (
        input  wr_en, input wr_tid, input wr_id, input wr_pid,
        input  rd_tid, output rd_id, output rd_pid
    );

endinterface

`default_nettype wire

/* source/thread_ctx_table.sv */
`timescale 1ns/100ps
`default_nettype none

`include "l15_adapter_cfg.svh"

module thread_ctx_table import hpdc_mem_pkg::*; (
    input  logic clk_i,
    input  logic rst_ni,
    thread_ctx_if.ctx_table ctx
);

    // Context per L1.5 thread id
    mem_id_t  id_q  [`NUM_TIDS];
    mem_pid_t pid_q [`NUM_TIDS];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < `NUM_TIDS; i++) begin
                id_q[i]  <= '0;
                pid_q[i] <= '0;
            end
        end else if (ctx.wr_en) begin
            id_q[ctx.wr_tid]  <= ctx.wr_id;
            pid_q[ctx.wr_tid] <= ctx.wr_pid;
        end
    end

    // Lookup for the return path
    assign ctx.rd_id  = id_q[ctx.rd_tid];
    assign ctx.rd_pid = pid_q[ctx.rd_tid];

endmodule

`default_nettype wire

/* source/thread_id_free_list.sv */
`timescale 1ns/100ps
`default_nettype none

`include "l15_adapter_cfg.svh"

module thread_id_free_list import l15_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_ni,
    input  logic     pop_i,
    input  logic     push_i,
    input  l15_tid_t push_tid_i,
    output logic     avail_o,
    output l15_tid_t head_tid_o
);

    localparam int cnt_w = $clog2(`NUM_TIDS + 1);

    l15_tid_t             tid_q [`NUM_TIDS];
    l15_tid_t             rd_ptr_q;   // Wraps naturally, depth is a power of two
    l15_tid_t             wr_ptr_q;
    logic [cnt_w-1:0]     count_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < `NUM_TIDS; i++) begin
                tid_q[i] <= l15_tid_t'(i);  // Starts full, ascending
            end
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= cnt_w'(`NUM_TIDS);
        end else begin
            if (push_i) begin
                tid_q[wr_ptr_q] <= push_tid_i;
                wr_ptr_q        <= wr_ptr_q + 1'b1;
            end
            if (pop_i) rd_ptr_q <= rd_ptr_q + 1'b1;
            case ({pop_i, push_i})
                2'b10:   count_q <= count_q - 1'b1;
                2'b01:   count_q <= count_q + 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    assign avail_o    = (count_q != '0);
    assign head_tid_o = tid_q[rd_ptr_q];

endmodule

`default_nettype wire
